/* lcu_sao.f */
lcu_sao_pkg.sv
lcu_sao_seq.sv
sao_line_ram.sv
sao_neighbor_sel.sv
sao_band_apply.sv
lcu_sao_top.sv
lcu_sao_tb.sv

/* Bender.yml */
package:
  name: lcu_sao

sources:
  - lcu_sao_pkg.sv
  - lcu_sao_seq.sv
  - sao_line_ram.sv
  - sao_neighbor_sel.sv
  - sao_band_apply.sv
  - lcu_sao_top.sv
  - target: simulation
    files:
      - lcu_sao_tb.sv

/* lcu_sao_tb.sv */
// testbench of the LCU SAO stage: clock, reset, pixel buffer model, reference model, checks
`timescale 1ns/1ps
`default_nettype none

module lcu_sao_tb;

    localparam int          LAST_POS   = lcu_sao_pkg::LOAD_LEN + lcu_sao_pkg::OUTLT_LEN +
                                         lcu_sao_pkg::OUT_LEN - 1;   // last read of an lcu
    localparam int          MAX_CYCLES = 12 * 330 + 100;
    localparam logic [31:0] SEED       = 32'h68a2_18ae;

    // expected write port entry, two stages deep
    typedef struct packed {
        logic                   ren;
        logic                   last;
        lcu_sao_pkg::pix_idx_t  idx;
        lcu_sao_pkg::pix_word_t word;
    } ref_entry_t;

    logic clk, rst_n, start_i;
    lcu_sao_pkg::lcu_pos_t   pos_i;
    lcu_sao_pkg::sao_param_t sao_param_i;
    lcu_sao_pkg::pix_word_t  pix_rdata_i, db_wdata_o, rd_data, ref_wdata;
    lcu_sao_pkg::pix_idx_t   pix_idx_o, db_widx_o, ref_widx, exp_idx;
    logic pix_ren_o, db_wen_o, done_o, ref_wen, ref_done, exp_ren, start_seen;
    ref_entry_t st1, st2;
    lcu_sao_pkg::sao_param_t m_cur, m_top, m_left, m_tl;
    lcu_sao_pkg::sao_param_t line_m [256];              // model of the line ram
    int seq_pos, lcu_num, wr_cnt, err_cnt, err_base, n_tests, clip_lo, clip_hi, cyc;
    logic [31:0] rng;

    lcu_sao_top dut (
        .clk (clk), .rst_n (rst_n), .start_i (start_i), .pos_i (pos_i),
        .sao_param_i (sao_param_i), .done_o (done_o), .pix_ren_o (pix_ren_o),
        .pix_idx_o (pix_idx_o), .pix_rdata_i (pix_rdata_i), .db_wen_o (db_wen_o),
        .db_widx_o (db_widx_o), .db_wdata_o (db_wdata_o)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        begin
            y = x ^ (x << 13);
            y = y ^ (y >> 17);
            return y ^ (y << 5);
        end
    endfunction

    // pixel buffer contents, hash of lcu number, word index and pixel
    function automatic lcu_sao_pkg::pix_word_t buf_word(input int lcu,
                                                        input lcu_sao_pkg::pix_idx_t idx);
        lcu_sao_pkg::pix_word_t w;
        logic [31:0]            h;
        begin
            for (int k = 0; k < lcu_sao_pkg::PIX_PER_WORD; k++) begin
                h = xorshift(xorshift(xorshift(SEED ^ (32'(lcu) << 20) ^ (32'(idx) << 8) ^ 32'(k))));
                w[8*k +: 8] = h[15:8] ^ h[31:24];
            end
            return w;
        end
    endfunction

    // parameter valid for one word, windows in priority order
    function automatic lcu_sao_pkg::sao_param_t nbr_param(input lcu_sao_pkg::pix_idx_t idx);
        int   c;
        logic xnz, ynz, xl, yl;
        begin
            c   = int'(idx.cnt);
            xnz = (pos_i.mb_x != 0);
            ynz = (pos_i.mb_y != 0);
            xl  = (pos_i.mb_x == pos_i.mb_x_total);
            yl  = (pos_i.mb_y == pos_i.mb_y_total);
            if (idx.prev) begin
                if (c == 48 && xnz && ynz) return m_tl;
                if (c < 16 && (yl || (xnz && c != 15))) return m_left;
                if (c >= 32 && c < 48 && ynz) return m_top;
                return '0;
            end
            if ((c % 16 == 15 && !xl) || (c / 16 == 15 && !yl))
                return '0;                               // border word, later lcu
            return m_cur;
        end
    endfunction

    function automatic lcu_sao_pkg::pix_word_t apply_band(input lcu_sao_pkg::pix_word_t din,
                                                          input lcu_sao_pkg::sao_param_t p);
        lcu_sao_pkg::pix_word_t dout;
        int                     pix, d, v;
        begin
            dout = din;
            for (int k = 0; k < lcu_sao_pkg::PIX_PER_WORD; k++) begin
                pix = int'(din[8*k +: 8]);
                d   = (pix / 8 - int'(p.band_pos) + 32) % 32;   // distance from first band
                if (d < 4) begin
                    v = pix + int'($signed(p.off[d]));
                    if (v < 0) begin
                        v = 0;
                        clip_lo++;
                    end else if (v > 255) begin
                        v = 255;
                        clip_hi++;
                    end
                    dout[8*k +: 8] = 8'(v);
                end
            end
            return dout;
        end
    endfunction

    function automatic lcu_sao_pkg::sao_param_t next_param();
        rng = xorshift(rng);
        return lcu_sao_pkg::sao_param_t'(rng[16:0]);
    endfunction

    // ********************
    // buffer and reference model
    // ********************
    always @(posedge clk) begin
        start_seen = start_i;
        #1;
        if (!rst_n) begin
            {st1, st2, ref_wen, ref_done, ref_widx, ref_wdata} = '0;
            {m_cur, m_top, m_left, m_tl} = '0;
            {exp_ren, exp_idx, rd_data} = '0;
            seq_pos = -1;
        end else begin
            ref_wen   = st2.ren;                         // what the write port shows now
            ref_widx  = st2.idx;
            ref_wdata = st2.word;
            ref_done  = st2.last;
            st2       = st1;
            pix_rdata_i = rd_data;                       // answer to last cycle's read
            if (seq_pos < 0) begin
                if (start_seen) begin
                    seq_pos = 0;
                    m_cur   = sao_param_i;
                    m_top   = line_m[pos_i.mb_x];
                    line_m[pos_i.mb_x] = sao_param_i;
                end
            end else begin
                seq_pos++;
                if (seq_pos > LAST_POS)
                    seq_pos = -1;
            end
            exp_ren = (seq_pos >= lcu_sao_pkg::LOAD_LEN);
            exp_idx.prev = (seq_pos < lcu_sao_pkg::LOAD_LEN + lcu_sao_pkg::OUTLT_LEN);
            exp_idx.cnt  = exp_idx.prev ? 8'(seq_pos - lcu_sao_pkg::LOAD_LEN) :
                           8'(seq_pos - lcu_sao_pkg::LOAD_LEN - lcu_sao_pkg::OUTLT_LEN);
            if (!exp_ren)
                exp_idx = '0;
            st1.ren  = exp_ren;
            st1.idx  = exp_idx;
            st1.last = (seq_pos == LAST_POS);
            st1.word = exp_ren ? apply_band(buf_word(lcu_num, exp_idx), nbr_param(exp_idx)) : '0;
            rd_data  = pix_ren_o ? buf_word(lcu_num, pix_idx_o) : '0;
            if (seq_pos == LAST_POS) begin               // neighbors move on
                m_left = m_cur;
                if (pos_i.mb_y != 0)
                    m_tl = m_top;
            end
        end
    end

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            wr_cnt <= 0;
        else if (db_wen_o)
            wr_cnt <= done_o ? 0 : wr_cnt + 1;           // writes of the running lcu
    end

    always @(posedge clk) begin
        cyc++;
        if (cyc >= MAX_CYCLES) begin
            $display("timeout: run did not end within %0d cycles", MAX_CYCLES);
            $display("TB FAILED");
            $finish;
        end
    end

    // ********************
    // checks
    // ********************
    a_ren : assert property (@(posedge clk) disable iff (!rst_n) pix_ren_o == exp_ren)
        else begin err_cnt++; $display("Mismatch at %0t: pix_ren_o got %b expected %b",
            $time, $sampled(pix_ren_o), exp_ren); end
    a_ridx : assert property (@(posedge clk) disable iff (!rst_n)
        pix_ren_o |-> pix_idx_o == exp_idx)
        else begin err_cnt++; $display("Mismatch at %0t: pix_idx_o got %h expected %h",
            $time, $sampled(pix_idx_o), exp_idx); end
    a_wen : assert property (@(posedge clk) disable iff (!rst_n) db_wen_o == ref_wen)
        else begin err_cnt++; $display("Mismatch at %0t: db_wen_o got %b expected %b",
            $time, $sampled(db_wen_o), ref_wen); end
    a_widx : assert property (@(posedge clk) disable iff (!rst_n)
        db_wen_o |-> db_widx_o == ref_widx)
        else begin err_cnt++; $display("Mismatch at %0t: db_widx_o got %h expected %h",
            $time, $sampled(db_widx_o), ref_widx); end
    a_wdata : assert property (@(posedge clk) disable iff (!rst_n)
        db_wen_o |-> db_wdata_o == ref_wdata)
        else begin err_cnt++; $display("Mismatch at %0t: db_wdata_o got %h expected %h",
            $time, $sampled(db_wdata_o), ref_wdata); end
    a_done : assert property (@(posedge clk) disable iff (!rst_n) done_o == ref_done)
        else begin err_cnt++; $display("Mismatch at %0t: done_o got %b expected %b",
            $time, $sampled(done_o), ref_done); end
    a_count : assert property (@(posedge clk) disable iff (!rst_n)
        done_o |-> db_wen_o && wr_cnt == 319)
        else begin err_cnt++; $display("done_o at %0t did not come with the 320th write (%0d before)",
            $time, $sampled(wr_cnt)); end

    // ********************
    // stimulus
    // ********************
    task automatic run_lcu(input lcu_sao_pkg::lcu_pos_t p, input lcu_sao_pkg::sao_param_t prm,
                           input int pulse_at);
        int n;
        begin
            n = 0;
            @(posedge clk);
            #1;
            pos_i       = p;
            sao_param_i = prm;
            lcu_num++;
            start_i     = 1'b1;
            do begin
                @(posedge clk);
                #1;
                n++;
                start_i = (n == pulse_at);                 // stray start while busy
            end while (!done_o);
            start_i = 1'b0;
        end
    endtask

    task automatic finish_test(input string name);
        n_tests++;
        $display("test %0d %s: %0d errors", n_tests, name, err_cnt - err_base);
        err_base = err_cnt;
    endtask

    initial begin
        {clk, rst_n, start_i, pos_i, sao_param_i, pix_rdata_i} = '0;
        {lcu_num, err_cnt, err_base, n_tests, clip_lo, clip_hi, cyc} = '0;
        rng = SEED;
        repeat (5) @(posedge clk);
        #1 rst_n = 1'b1;
        repeat (20) @(posedge clk);                       // quiet before any start
        run_lcu('{8'd0, 8'd0, 8'd0, 8'd0}, '0, -1);
        finish_test("reset and zero parameters");
        run_lcu('{8'd0, 8'd0, 8'd0, 8'd0}, next_param(), 100);
        finish_test("write timing and ignored start");
        for (int i = 0; i < 5; i++)                       // row 0, then up to (1,1)
            run_lcu('{8'(i % 3), 8'(i / 3), 8'd2, 8'd2}, next_param(), -1);
        finish_test("interior lcu");
        for (int i = 5; i < 8; i++)
            run_lcu('{8'(i % 3), 8'(i / 3), 8'd2, 8'd2}, next_param(), -1);
        finish_test("neighbor parameters");
        clip_lo = 0;
        clip_hi = 0;
        // bands 30,31,0,1 with +3 on band 31 and -4 on band 0
        run_lcu('{8'd2, 8'd2, 8'd2, 8'd2}, '{5'd30, '{3'b111, 3'b100, 3'b011, 3'b001}}, -1);
        a_clip : assert (clip_lo > 0 && clip_hi > 0)
            else begin err_cnt++; $display("clipping at 0 or 255 never happened"); end
        finish_test("edge windows and clipping");
        $display("tests run: %0d, errors: %0d", n_tests, err_cnt);
        if (err_cnt == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* lcu_sao_top.sv */
// top level of the LCU SAO stage: sequencer, neighbor select and band apply
`timescale 1ns/1ps
`default_nettype none

module lcu_sao_top #(
    parameter int ADDR_W = lcu_sao_pkg::PIC_W    // line ram index is mb_x
) (
    input  wire logic                     clk,
    input  wire logic                     rst_n,
    // lcu control
    input  wire logic                     start_i,
    input  wire lcu_sao_pkg::lcu_pos_t    pos_i,        // stable until done_o
    input  wire lcu_sao_pkg::sao_param_t  sao_param_i,  // stable until done_o
    output logic                          done_o,
    // pixel buffer read
    output logic                          pix_ren_o,
    output lcu_sao_pkg::pix_idx_t         pix_idx_o,
    input  wire lcu_sao_pkg::pix_word_t   pix_rdata_i,  // one cycle after ren
    // write port
    output logic                          db_wen_o,
    output lcu_sao_pkg::pix_idx_t         db_widx_o,
    output lcu_sao_pkg::pix_word_t        db_wdata_o
);

    lcu_sao_pkg::lcu_state_e state;
    lcu_sao_pkg::cnt_t       cnt;
    logic                    last;
    lcu_sao_pkg::sao_param_t sel_param;

    // ********************
    // instances
    // ********************
    lcu_sao_seq u_seq (
        .clk       (clk),
        .rst_n     (rst_n),
        .start_i   (start_i),
        .state_o   (state),
        .cnt_o     (cnt),
        .pix_ren_o (pix_ren_o),
        .pix_idx_o (pix_idx_o),
        .last_o    (last)
    );

    sao_neighbor_sel #(
        .ADDR_W (ADDR_W)
    ) u_nbr (
        .clk         (clk),
        .rst_n       (rst_n),
        .state_i     (state),
        .cnt_i       (cnt),
        .pos_i       (pos_i),
        .sao_param_i (sao_param_i),
        .sel_param_o (sel_param)
    );

    sao_band_apply u_band (
        .clk         (clk),
        .rst_n       (rst_n),
        .pix_ren_i   (pix_ren_o),
        .pix_idx_i   (pix_idx_o),
        .last_i      (last),
        .sel_param_i (sel_param),
        .pix_rdata_i (pix_rdata_i),
        .db_wen_o    (db_wen_o),
        .db_widx_o   (db_widx_o),
        .db_wdata_o  (db_wdata_o),
        .done_o      (done_o)
    );

endmodule

`default_nettype wire

/* sao_band_apply.sv */
// SAO band offset add with clipping, strobe/index delay line and output register stage
`timescale 1ns/1ps
`default_nettype none

module sao_band_apply (
    input  wire logic                     clk,
    input  wire logic                     rst_n,
    input  wire logic                     pix_ren_i,
    input  wire lcu_sao_pkg::pix_idx_t    pix_idx_i,
    input  wire logic                     last_i,
    input  wire lcu_sao_pkg::sao_param_t  sel_param_i,   // one cycle after ren
    input  wire lcu_sao_pkg::pix_word_t   pix_rdata_i,   // one cycle after ren
    output logic                          db_wen_o,
    output lcu_sao_pkg::pix_idx_t         db_widx_o,
    output lcu_sao_pkg::pix_word_t        db_wdata_o,
    output logic                          done_o
);

    logic                   ren_d1;
    logic                   last_d1;
    lcu_sao_pkg::pix_idx_t  idx_d1;
    lcu_sao_pkg::pix_word_t sao_word;

    // band offset on one pixel, clipped to 0..255
    function automatic logic [7:0] band_off(
        input logic [7:0]              pix,
        input lcu_sao_pkg::sao_param_t prm
    );
        logic [4:0] rel;
        logic [2:0] off;
        logic [9:0] sum;
        begin
            rel = pix[7:3] - prm.band_pos;       // wraps mod 32
            off = prm.off[rel[1:0]];
            sum = {2'b00, pix} + {{7{off[2]}}, off};
            if (rel >= 5'd4)
                band_off = pix;                  // outside the four bands
            else if (sum[9])
                band_off = 8'd0;                 // below zero
            else if (sum[8])
                band_off = 8'd255;
            else
                band_off = sum[7:0];
        end
    endfunction

    // ********************
    // data path
    // ********************
    always_comb begin
        for (int k = 0; k < lcu_sao_pkg::PIX_PER_WORD; k++) begin
            sao_word[k*lcu_sao_pkg::PIX_W +: lcu_sao_pkg::PIX_W] =
                band_off(pix_rdata_i[k*lcu_sao_pkg::PIX_W +: lcu_sao_pkg::PIX_W], sel_param_i);
        end
    end

    always_ff @(posedge clk) begin
        idx_d1     <= pix_idx_i;
        db_widx_o  <= idx_d1;
        db_wdata_o <= sao_word;                  // second stage
    end

    // ********************
    // control delay
    // ********************
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ren_d1   <= 1'b0;
            last_d1  <= 1'b0;
            db_wen_o <= 1'b0;
            done_o   <= 1'b0;
        end else begin
            ren_d1   <= pix_ren_i;
            last_d1  <= last_i;
            db_wen_o <= ren_d1;                  // ren + 2
            done_o   <= last_d1;                 // with the final write
        end
    end

endmodule

`default_nettype wire

/* sao_neighbor_sel.sv */
// current, top, left and top-left SAO parameter registers, window flags and priority select
`timescale 1ns/1ps
`default_nettype none

module sao_neighbor_sel #(
    parameter int ADDR_W = 8
) (
    input  wire logic                     clk,
    input  wire logic                     rst_n,
    input  wire lcu_sao_pkg::lcu_state_e  state_i,
    input  wire lcu_sao_pkg::cnt_t        cnt_i,
    input  wire lcu_sao_pkg::lcu_pos_t    pos_i,
    input  wire lcu_sao_pkg::sao_param_t  sao_param_i,
    output lcu_sao_pkg::sao_param_t       sel_param_o   // lines up with pixel data
);

    logic                    in_load;
    logic                    in_outlt;
    logic                    in_out;
    logic                    x_nz, y_nz;        // not first column / row
    logic                    x_last, y_last;    // last column / row
    logic                    out_end;

    logic                    ram_en, ram_we;
    logic [ADDR_W-1:0]       ram_addr;
    lcu_sao_pkg::sao_param_t ram_rdata;

    lcu_sao_pkg::sao_param_t curr_r, top_r, left_r, tl_r;
    logic                    tl_v, left_v, top_v, curr_v;

    assign in_load  = (state_i == lcu_sao_pkg::ST_LOAD);
    assign in_outlt = (state_i == lcu_sao_pkg::ST_OUTLT);
    assign in_out   = (state_i == lcu_sao_pkg::ST_OUT);
    assign x_nz     = (pos_i.mb_x != '0);
    assign y_nz     = (pos_i.mb_y != '0);
    assign x_last   = (pos_i.mb_x == pos_i.mb_x_total);
    assign y_last   = (pos_i.mb_y == pos_i.mb_y_total);
    assign out_end  = in_out && (cnt_i == lcu_sao_pkg::cnt_t'(lcu_sao_pkg::OUT_LEN - 1));

    // ********************
    // line ram access
    // ********************
    // cnt 0 reads the slot of the lcu above, cnt 1 writes current back
    assign ram_en   = in_load;
    assign ram_we   = in_load && cnt_i[0];
    assign ram_addr = ADDR_W'(pos_i.mb_x);

    sao_line_ram #(
        .ADDR_W (ADDR_W)
    ) u_line_ram (
        .clk     (clk),
        .en_i    (ram_en),
        .we_i    (ram_we),
        .addr_i  (ram_addr),
        .wdata_i (curr_r),
        .rdata_o (ram_rdata)
    );

    // ********************
    // parameter registers
    // ********************
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            curr_r <= '0;
            top_r  <= '0;
            left_r <= '0;
            tl_r   <= '0;
        end else begin
            if (in_load && (cnt_i == 8'd0))
                curr_r <= sao_param_i;           // held until next lcu
            if (in_load && (cnt_i == 8'd1))
                top_r  <= ram_rdata;             // read issued at cnt 0
            if (out_end) begin
                left_r <= curr_r;
                if (y_nz)
                    tl_r <= top_r;
            end
        end
    end

    // ********************
    // windows
    // ********************
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tl_v   <= 1'b0;
            left_v <= 1'b0;
            top_v  <= 1'b0;
            curr_v <= 1'b0;
        end else begin
            tl_v   <= in_outlt && (cnt_i == 8'd48) && x_nz && y_nz;
            // words 0..15, last word only in the last row
            left_v <= in_outlt && (cnt_i[7:4] == 4'd0) &&
                      (y_last || (x_nz && (cnt_i[3:0] != 4'hf)));
            top_v  <= in_outlt && (cnt_i[7:4] == 4'd2) && y_nz;   // 32..47
            // right column and bottom row wait for the next lcu unless at the edge
            curr_v <= in_out &&
                      !((cnt_i[3:0] == 4'hf) && !x_last) &&
                      !((cnt_i[7:4] == 4'hf) && !y_last);
        end
    end

    // priority select
    always_comb begin
        if (tl_v)
            sel_param_o = tl_r;
        else if (left_v)
            sel_param_o = left_r;
        else if (top_v)
            sel_param_o = top_r;
        else if (curr_v)
            sel_param_o = curr_r;
        else
            sel_param_o = '0;                    // no change to pixels
    end

    // windows are disjoint in cnt, so the priority never has to decide
    a_one_window : assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0({tl_v, left_v, top_v, curr_v}));

endmodule

`default_nettype wire

/* sao_line_ram.sv */
// single-port line RAM of SAO parameters, one word per LCU column, registered read
`timescale 1ns/1ps
`default_nettype none

module sao_line_ram #(
    parameter int ADDR_W = 8
) (
    input  wire logic                  clk,
    input  wire logic                  en_i,
    input  wire logic                  we_i,     // 1: write, 0: read
    input  wire logic [ADDR_W-1:0]     addr_i,   // lcu column
    input  wire lcu_sao_pkg::sao_param_t wdata_i,
    output lcu_sao_pkg::sao_param_t    rdata_o
);

    lcu_sao_pkg::sao_param_t mem [2**ADDR_W];

    // ********************
    // port
    // ********************
    always_ff @(posedge clk) begin
        if (en_i) begin
            if (we_i)
                mem[addr_i] <= wdata_i;
            else
                rdata_o <= mem[addr_i];      // one cycle latency
        end
    end

    // control must be known whenever the port might act
    a_ctrl_known : assert property (@(posedge clk)
        !$isunknown(en_i) && (!en_i || !$isunknown(we_i)));

endmodule

`default_nettype wire

/* lcu_sao_seq.sv */
// per-LCU phase FSM with cycle counter, pixel read strobe and last pulse
`timescale 1ns/1ps
`default_nettype none

module lcu_sao_seq (
    input  wire logic                    clk,
    input  wire logic                    rst_n,
    input  wire logic                    start_i,     // only taken in idle
    output lcu_sao_pkg::lcu_state_e      state_o,
    output lcu_sao_pkg::cnt_t            cnt_o,
    output logic                         pix_ren_o,
    output lcu_sao_pkg::pix_idx_t        pix_idx_o,
    output logic                         last_o       // final OUT cycle
);

    lcu_sao_pkg::lcu_state_e state_r, state_nxt;
    lcu_sao_pkg::cnt_t       cnt_r, cnt_nxt;

    // ********************
    // next state
    // ********************
    always_comb begin
        state_nxt = state_r;
        cnt_nxt   = cnt_r + 8'd1;                    // counts within a phase
        case (state_r)
            lcu_sao_pkg::ST_IDLE: begin
                cnt_nxt = '0;
                if (start_i)
                    state_nxt = lcu_sao_pkg::ST_LOAD;
            end
            lcu_sao_pkg::ST_LOAD: begin
                if (cnt_r == lcu_sao_pkg::cnt_t'(lcu_sao_pkg::LOAD_LEN - 1)) begin
                    state_nxt = lcu_sao_pkg::ST_OUTLT;
                    cnt_nxt   = '0;
                end
            end
            lcu_sao_pkg::ST_OUTLT: begin
                if (cnt_r == lcu_sao_pkg::cnt_t'(lcu_sao_pkg::OUTLT_LEN - 1)) begin
                    state_nxt = lcu_sao_pkg::ST_OUT;
                    cnt_nxt   = '0;
                end
            end
            default: begin                           // ST_OUT
                if (cnt_r == lcu_sao_pkg::cnt_t'(lcu_sao_pkg::OUT_LEN - 1)) begin
                    state_nxt = lcu_sao_pkg::ST_IDLE;
                    cnt_nxt   = '0;
                end
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_r <= lcu_sao_pkg::ST_IDLE;
            cnt_r   <= '0;
        end else begin
            state_r <= state_nxt;
            cnt_r   <= cnt_nxt;
        end
    end

    assign state_o        = state_r;
    assign cnt_o          = cnt_r;
    // one read per cycle in both output phases
    assign pix_ren_o      = (state_r == lcu_sao_pkg::ST_OUTLT) || (state_r == lcu_sao_pkg::ST_OUT);
    assign pix_idx_o.prev = (state_r == lcu_sao_pkg::ST_OUTLT);
    assign pix_idx_o.cnt  = cnt_r;
    assign last_o = (state_r == lcu_sao_pkg::ST_OUT) &&
                    (cnt_r == lcu_sao_pkg::cnt_t'(lcu_sao_pkg::OUT_LEN - 1));

    // counter stays inside the current phase
    a_cnt_in_phase : assert property (@(posedge clk) disable iff (!rst_n)
        ((state_r != lcu_sao_pkg::ST_IDLE)  || (cnt_r == '0)) &&
        ((state_r != lcu_sao_pkg::ST_LOAD)  || (cnt_r < lcu_sao_pkg::LOAD_LEN)) &&
        ((state_r != lcu_sao_pkg::ST_OUTLT) || (cnt_r < lcu_sao_pkg::OUTLT_LEN)));

endmodule

`default_nettype wire

/* lcu_sao_pkg.sv */
// widths, FSM state enum, phase lengths and packed structs of the SAO stage
`default_nettype none

package lcu_sao_pkg;

    // ********************
    // widths
    // ********************
    localparam int PIC_W        = 8;                 // lcu coordinate
    localparam int PIX_W        = 8;                 // one pixel
    localparam int PIX_PER_WORD = 16;                // pixels per data word

    typedef logic [PIX_PER_WORD*PIX_W-1:0] pix_word_t;  // pixel k at [8k+7:8k]

    // band offset parameter, 17 bits
    typedef struct packed {
        logic [4:0]      band_pos;                   // first of four bands
        logic [3:0][2:0] off;                        // signed, off[i] for band_pos+i
    } sao_param_t;

    // lcu position in the picture, totals are the last index
    typedef struct packed {
        logic [PIC_W-1:0] mb_x;
        logic [PIC_W-1:0] mb_y;
        logic [PIC_W-1:0] mb_x_total;
        logic [PIC_W-1:0] mb_y_total;
    } lcu_pos_t;

    // ********************
    // sequencer
    // ********************
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_LOAD,                                     // param capture, line ram access
        ST_OUTLT,                                    // border words of earlier lcus
        ST_OUT                                       // words of the current lcu
    } lcu_state_e;

    localparam int LOAD_LEN  = 2;
    localparam int OUTLT_LEN = 64;
    localparam int OUT_LEN   = 256;

    typedef logic [7:0] cnt_t;

    typedef struct packed {
        logic prev;                                  // 1: word sent during OUTLT
        cnt_t cnt;
    } pix_idx_t;

endpackage

`default_nettype wire
